// ==== filelist.f ====
common/pipe_pkg.sv
hw/instr_mem.sv
hw/reg_file.sv
hw/hazard_unit.sv
hw/pipeline_core.sv
pipe_trace/pipe_trace.sv
hw/cpu_top.sv
tb/tb_cpu_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_cpu_top
FILELIST  ?= filelist.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir

// ==== tb/tb_cpu_top.sv ====
`timescale 1ns/10ps

module tb_cpu_top;
    import pipe_pkg::*;

    localparam int IMEM_DEPTH   = 64;
    localparam int DMEM_DEPTH   = 64;
    localparam int CYCLE_W      = 16;
    localparam int HALT_TIMEOUT = 400;
    localparam int QUIET        = 24;
    localparam logic [31:0] SEED = 32'hd4db_1dc0;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 prog_we;
    logic [5:0]           prog_addr;
    logic [XLEN-1:0]      prog_data;
    logic                 retire_valid;
    logic [5:0]           retire_pc;
    logic [XLEN-1:0]      retire_instr;
    logic [REG_W-1:0]     retire_rd;
    logic [XLEN-1:0]      retire_data;
    logic                 retire_we;
    logic [STALL_W-1:0]   retire_stalls;
    logic [CYCLE_W-1:0]   retire_fetch_cycle;
    logic [CYCLE_W-1:0]   retire_cycle;
    logic                 halted;

    // Expected retire record of each program address
    logic [XLEN-1:0] e_word   [IMEM_DEPTH];
    logic            e_we     [IMEM_DEPTH];
    int              e_rd     [IMEM_DEPTH];
    logic [XLEN-1:0] e_data   [IMEM_DEPTH];
    int              e_stalls [IMEM_DEPTH];
    int              e_fcyc   [IMEM_DEPTH];
    int              e_rcyc   [IMEM_DEPTH];
    int              e_test   [IMEM_DEPTH];
    int              exp_q [$];
    int              n_prog = 0;

    // Architectural state of the reference model
    logic [XLEN-1:0] regs_m [8] = '{default: '0};
    logic [XLEN-1:0] dmem_m [DMEM_DEPTH];
    int              wr_t [8] = '{default: -100};
    int              last_t = 0;
    int              recent1 = 0;
    int              recent2 = 0;

    string names [1:6] = '{"reset", "independent", "dependent", "memory", "ordering", "halt"};
    int    fails [1:6] = '{default: 0};
    bit    reported [1:6] = '{default: 1'b0};
    int    last_of [1:6] = '{default: -1};
    int    n_pass = 0;
    int    n_fail = 0;

    int cyc = 0;
    int halt_cyc = -1;
    int prev_pc;
    int prev_fcyc;
    int prev_rcyc;
    int prev_stalls;

    cpu_top #(
        .IMEM_DEPTH(IMEM_DEPTH),
        .DMEM_DEPTH(DMEM_DEPTH),
        .CYCLE_W(CYCLE_W)
    ) DUT (
        .clk, .rst, .prog_we, .prog_addr, .prog_data,
        .retire_valid, .retire_pc, .retire_instr, .retire_rd, .retire_data,
        .retire_we, .retire_stalls, .retire_fetch_cycle, .retire_cycle, .halted
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic check_field(input string what, input int got, input int exp, input int test);
        assert (got == exp) else begin
            $display("error %0t: %s got %0d expected %0d (test %0d)", $time, what, got, exp, test);
            fails[test]++;
        end
    endtask

    task automatic report_test(input int t);
        reported[t] = 1'b1;
        if (fails[t] == 0) begin
            n_pass++;
            $display("test %0d %s: passed", t, names[t]);
        end else begin
            n_fail++;
            $display("test %0d %s: failed with %0d errors", t, names[t], fails[t]);
        end
    endtask

    // Cycle in which a source becomes safe to read in decode
    function automatic int ready_cycle(input int r);
        if (r == 0) begin
            return 0;
        end
        return wr_t[r] + 3;
    endfunction

    // A register that neither of the last two instructions writes
    function automatic int free_reg();
        int r;
        r = 1 + int'($urandom % 7);
        while (r == recent1 || r == recent2) begin
            r = 1 + int'($urandom % 7);
        end
        return r;
    endfunction

    function automatic int rand_imm();
        return int'($urandom % 64) - 32;
    endfunction

    // Encode one instruction, execute it in the model and queue its record
    task automatic emit(input logic [3:0] op, input int rd, input int rs1, input int rs2,
                        input int imm, input int test);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] res;
        logic [5:0]      addr;
        logic            is_r;
        logic            writes;
        int              d;
        int              t;
        is_r   = op inside {OP_ADD, OP_SUB, OP_AND, OP_OR};
        writes = is_r || op == OP_ADDI || op == OP_LD;
        if (is_r) begin
            e_word[n_prog] = {op, 3'(rd), 3'(rs1), 3'(rs2), 3'b000};
        end else begin
            e_word[n_prog] = {op, 3'(rd), 3'(rs1), 6'(imm)};
        end
        a = regs_m[rs1];
        b = is_r ? regs_m[rs2] : 16'(imm);
        case (op)
            OP_SUB:  res = a - b;
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            default: res = a + b;
        endcase
        addr = res[5:0];
        if (op == OP_LD) begin
            res = dmem_m[addr];
        end
        if (op == OP_ST) begin
            dmem_m[addr] = regs_m[rd];
        end
        // Without forwarding decode waits while a producer is in execute or memory
        d = last_t + 1;
        t = d;
        if (is_r || op inside {OP_ADDI, OP_LD, OP_ST}) begin
            t = (ready_cycle(rs1) > t) ? ready_cycle(rs1) : t;
        end
        if (is_r) begin
            t = (ready_cycle(rs2) > t) ? ready_cycle(rs2) : t;
        end
        if (op == OP_ST) begin
            t = (ready_cycle(rd) > t) ? ready_cycle(rd) : t;
        end
        e_we[n_prog]     = writes;
        e_rd[n_prog]     = rd;
        e_data[n_prog]   = res;
        e_stalls[n_prog] = t - d;
        e_fcyc[n_prog]   = d - 1;
        e_rcyc[n_prog]   = t + 3;
        e_test[n_prog]   = test;
        if (writes && rd != 0) begin
            regs_m[rd] = res;
            wr_t[rd]   = t;
        end
        last_t  = t;
        recent2 = recent1;
        recent1 = (writes && rd != 0) ? rd : 0;
        last_of[test] = n_prog;
        exp_q.push_back(n_prog);
        n_prog++;
    endtask

    task automatic build_program();
        logic [3:0] op;
        int rd;
        int rs1;
        int rs2;
        int imm;
        int p;
        for (int r = 1; r < 8; r++) begin
            emit(OP_ADDI, r, 0, 0, rand_imm(), 2);
        end
        for (int n = 0; n < 8; n++) begin
            case ($urandom % 5)
                0: op = OP_ADD;
                1: op = OP_SUB;
                2: op = OP_AND;
                3: op = OP_OR;
                default: op = OP_ADDI;
            endcase
            rd  = 1 + int'($urandom % 7);
            rs1 = free_reg();
            rs2 = free_reg();
            imm = rand_imm();
            emit(op, rd, rs1, rs2, imm, 2);
        end
        for (int n = 0; n < 3; n++) begin
            // Consumer right behind its producer
            p   = 1 + int'($urandom % 7);
            rs1 = free_reg();
            rs2 = free_reg();
            emit(OP_ADD, p, rs1, rs2, 0, 3);
            rd  = free_reg();
            rs2 = free_reg();
            emit(OP_SUB, rd, p, rs2, 0, 3);
            // One independent instruction in between
            p   = free_reg();
            rs1 = free_reg();
            emit(OP_ADDI, p, rs1, 0, rand_imm(), 3);
            rd  = free_reg();
            emit(OP_ADDI, rd, 0, 0, rand_imm(), 3);
            rs2 = free_reg();
            rd  = 1 + int'($urandom % 7);
            emit(OP_AND, rd, p, rs2, 0, 3);
        end
        for (int n = 0; n < 2; n++) begin
            rd  = free_reg();
            emit(OP_ADDI, rd, 0, 0, rand_imm(), 4);
            rs1 = free_reg();
            emit(OP_ADDI, rs1, 0, 0, int'($urandom % 24), 4);
            imm = rand_imm();
            emit(OP_ST, rd, rs1, 0, imm, 4);
            // Overwrite the stored register so LD must read memory
            emit(OP_ADDI, rd, 0, 0, rand_imm(), 4);
            emit(OP_NOP, 0, 0, 0, 0, 4);
            rs2 = free_reg();
            emit(OP_LD, rs2, rs1, 0, imm, 4);
        end
        emit(OP_HALT, 0, 0, 0, 0, 6);
    endtask

    task automatic load_program();
        for (int a = 0; a < n_prog; a++) begin
            @(negedge clk);
            prog_we   = 1'b1;
            prog_addr = 6'(a);
            prog_data = e_word[a];
        end
        @(negedge clk);
        prog_we = 1'b0;
    endtask

    task automatic check_retire();
        int k;
        int t;
        if (exp_q.size() == 0) begin
            $display("a retire strobe came after the whole program had retired, at %0t", $time);
            fails[6]++;
            return;
        end
        k = exp_q.pop_front();
        t = e_test[k];
        check_field("pc", int'(retire_pc), k, t);
        check_field("instr", int'(retire_instr), int'(e_word[k]), t);
        check_field("we", int'(retire_we), int'(e_we[k]), t);
        if (e_we[k]) begin
            check_field("rd", int'(retire_rd), e_rd[k], t);
            check_field("data", int'(retire_data), int'(e_data[k]), t);
        end
        check_field("stalls", int'(retire_stalls), e_stalls[k], t);
        check_field("fetch cycle", int'(retire_fetch_cycle), e_fcyc[k], t);
        check_field("retire cycle", int'(retire_cycle), e_rcyc[k], t);
        check_field("retire latency", int'(retire_cycle),
                    int'(retire_fetch_cycle) + 4 + int'(retire_stalls), t);
        if (k == 0) begin
            check_field("first pc", int'(retire_pc), 0, 1);
            check_field("first fetch cycle", int'(retire_fetch_cycle), 0, 1);
            report_test(1);
        end else begin
            check_field("pc step", int'(retire_pc), prev_pc + 1, 5);
            check_field("fetch cycle step", int'(retire_fetch_cycle) - prev_fcyc,
                        1 + prev_stalls, 5);
            check_field("retire cycle step", int'(retire_cycle) - prev_rcyc,
                        1 + int'(retire_stalls), 5);
        end
        prev_pc     = int'(retire_pc);
        prev_fcyc   = int'(retire_fetch_cycle);
        prev_rcyc   = int'(retire_cycle);
        prev_stalls = int'(retire_stalls);
        if (k == n_prog - 1) begin
            halt_cyc = cyc;
            check_field("halted at halt retire", int'(halted), 0, 6);
            report_test(5);
        end else if (t >= 2 && t <= 4 && k == last_of[t]) begin
            report_test(t);
        end
    endtask

    always @(negedge clk) begin
        if (!rst && retire_valid) begin
            check_retire();
        end
    end

    task automatic wait_halted(output bit ok);
        int n;
        n = 0;
        while (!halted && n < HALT_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        ok = halted;
    endtask

    // Core stays halted and silent after HALT
    task automatic quiet_window();
        for (int q = 0; q < QUIET; q++) begin
            @(negedge clk);
            check_field("halted held", int'(halted), 1, 6);
        end
        // Include any strobe checked on the last falling edge
        @(posedge clk);
        if (exp_q.size() != 0) begin
            $display("%0d instructions never retired", exp_q.size());
            fails[6]++;
        end
        report_test(6);
    endtask

    task automatic close_tests();
        for (int t = 1; t <= 5; t++) begin
            if (!reported[t]) begin
                $display("test %0d %s never reached its last retire", t, names[t]);
                fails[t]++;
                report_test(t);
            end
        end
    endtask

    initial begin
        bit ok;
        void'($urandom(SEED));
        rst       = 1'b1;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        build_program();
        load_program();
        repeat (3) @(negedge clk);
        check_field("retire_valid in reset", int'(retire_valid), 0, 1);
        check_field("halted in reset", int'(halted), 0, 1);
        rst = 1'b0;
        @(negedge clk);
        check_field("retire_valid after reset", int'(retire_valid), 0, 1);
        check_field("halted after reset", int'(halted), 0, 1);
        wait_halted(ok);
        if (!ok) begin
            $display("timeout: halted did not rise within %0d cycles", HALT_TIMEOUT);
            $display("Test FAILED");
            $finish;
        end else begin
            check_field("halted rise cycle", cyc, halt_cyc + 1, 6);
            quiet_window();
            close_tests();
            $display("tests run %0d, passed %0d, failed %0d", n_pass + n_fail, n_pass, n_fail);
            if (n_fail == 0) begin
                $display("Test OK");
            end else begin
                $display("Test FAILED");
            end
            $finish;
        end
    end

endmodule

// ==== hw/cpu_top.sv ====
`timescale 1ns/10ps

module cpu_top #(
    parameter int IMEM_DEPTH = 64,
    parameter int DMEM_DEPTH = 64,
    parameter int CYCLE_W    = 16
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          prog_we,
    input  logic [$clog2(IMEM_DEPTH)-1:0] prog_addr,
    input  logic [pipe_pkg::XLEN-1:0]     prog_data,
    output logic                          retire_valid,
    output logic [$clog2(IMEM_DEPTH)-1:0] retire_pc,
    output logic [pipe_pkg::XLEN-1:0]     retire_instr,
    output logic [pipe_pkg::REG_W-1:0]    retire_rd,
    output logic [pipe_pkg::XLEN-1:0]     retire_data,
    output logic                          retire_we,
    output logic [pipe_pkg::STALL_W-1:0]  retire_stalls,
    output logic [CYCLE_W-1:0]            retire_fetch_cycle,
    output logic [CYCLE_W-1:0]            retire_cycle,
    output logic                          halted
);
    import pipe_pkg::*;

    localparam int PC_W = $clog2(IMEM_DEPTH);

    logic [PC_W-1:0]  fetch_pc;
    logic [XLEN-1:0]  fetch_instr;
    logic [REG_W-1:0] rs1_addr;
    logic [REG_W-1:0] rs2_addr;
    logic [XLEN-1:0]  rs1_data;
    logic [XLEN-1:0]  rs2_data;
    logic             wb_we;
    logic [REG_W-1:0] wb_rd;
    logic [XLEN-1:0]  wb_data;
    logic [REG_W-1:0] ex_rd;
    logic             ex_writes;
    logic [REG_W-1:0] mem_rd;
    logic             mem_writes;
    instr_u           dec_instr;
    logic             dec_valid;
    logic             stall;
    logic             fetch_fire;
    logic             wb_fire;

    instr_mem #(.IMEM_DEPTH(IMEM_DEPTH)) u_imem (
        .clk, .prog_we, .prog_addr, .prog_data, .fetch_pc, .fetch_instr
    );

    reg_file u_rf (
        .clk, .rst, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data, .wb_we, .wb_rd, .wb_data
    );

    hazard_unit u_hazard (
        .clk, .rst, .dec_instr, .dec_valid, .ex_rd, .ex_writes, .mem_rd, .mem_writes, .stall
    );

    pipeline_core #(
        .IMEM_DEPTH(IMEM_DEPTH),
        .DMEM_DEPTH(DMEM_DEPTH)
    ) u_core (
        .clk, .rst, .fetch_pc, .fetch_instr, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .wb_we, .wb_rd, .wb_data, .ex_rd, .ex_writes, .mem_rd, .mem_writes,
        .dec_instr, .dec_valid, .stall, .fetch_fire, .wb_fire, .halted
    );

    pipe_trace #(
        .IMEM_DEPTH(IMEM_DEPTH),
        .CYCLE_W(CYCLE_W)
    ) u_trace (
        .clk, .rst, .fetch_fire, .fetch_pc, .fetch_instr, .stall,
        .wb_fire, .wb_rd, .wb_data, .wb_we,
        .retire_valid, .retire_pc, .retire_instr, .retire_rd, .retire_data,
        .retire_we, .retire_stalls, .retire_fetch_cycle, .retire_cycle
    );

endmodule

// ==== pipe_trace/pipe_trace.sv ====
`timescale 1ns/10ps

module pipe_trace #(
    parameter int IMEM_DEPTH = 64,
    parameter int CYCLE_W    = 16
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          fetch_fire,
    input  logic [$clog2(IMEM_DEPTH)-1:0] fetch_pc,
    input  logic [pipe_pkg::XLEN-1:0]     fetch_instr,
    input  logic                          stall,
    input  logic                          wb_fire,
    input  logic [pipe_pkg::REG_W-1:0]    wb_rd,
    input  logic [pipe_pkg::XLEN-1:0]     wb_data,
    input  logic                          wb_we,
    output logic                          retire_valid,
    output logic [$clog2(IMEM_DEPTH)-1:0] retire_pc,
    output logic [pipe_pkg::XLEN-1:0]     retire_instr,
    output logic [pipe_pkg::REG_W-1:0]    retire_rd,
    output logic [pipe_pkg::XLEN-1:0]     retire_data,
    output logic                          retire_we,
    output logic [pipe_pkg::STALL_W-1:0]  retire_stalls,
    output logic [CYCLE_W-1:0]            retire_fetch_cycle,
    output logic [CYCLE_W-1:0]            retire_cycle
);
    import pipe_pkg::*;

    localparam int PC_W  = $clog2(IMEM_DEPTH);
    // Slots 0..3 follow decode, execute, memory and writeback
    localparam int NSLOT = 4;
    localparam int WB    = NSLOT - 1;

    logic [CYCLE_W-1:0] cycle;
    logic               rec_valid  [NSLOT];
    logic [PC_W-1:0]    rec_pc     [NSLOT];
    logic [XLEN-1:0]    rec_instr  [NSLOT];
    logic [CYCLE_W-1:0] rec_fcyc   [NSLOT];
    logic [STALL_W-1:0] rec_stalls [NSLOT];

    always_ff @(posedge clk) begin
        if (rst) begin
            cycle <= '0;
        end else begin
            cycle <= cycle + 1'b1;
        end
    end

    // Slot valids track the core stage valids one for one
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NSLOT; i++) begin
                rec_valid[i] <= 1'b0;
            end
        end else begin
            if (!stall) begin
                rec_valid[0] <= fetch_fire;
            end
            rec_valid[1] <= rec_valid[0] && !stall;
            for (int i = 2; i < NSLOT; i++) begin
                rec_valid[i] <= rec_valid[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            rec_pc[0]     <= fetch_pc;
            rec_instr[0]  <= fetch_instr;
            rec_fcyc[0]   <= cycle;
            rec_stalls[0] <= '0;
        end else begin
            // Held in decode for one more cycle
            rec_stalls[0] <= rec_stalls[0] + 1'b1;
        end
        for (int i = 1; i < NSLOT; i++) begin
            rec_pc[i]     <= rec_pc[i-1];
            rec_instr[i]  <= rec_instr[i-1];
            rec_fcyc[i]   <= rec_fcyc[i-1];
            rec_stalls[i] <= rec_stalls[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= wb_fire;
        end
    end

    // retire_cycle carries the writeback cycle, one behind the strobe
    always_ff @(posedge clk) begin
        retire_pc          <= rec_pc[WB];
        retire_instr       <= rec_instr[WB];
        retire_rd          <= wb_rd;
        retire_data        <= wb_data;
        retire_we          <= wb_we;
        retire_stalls      <= rec_stalls[WB];
        retire_fetch_cycle <= rec_fcyc[WB];
        retire_cycle       <= cycle;
    end

    a_wb_slot_lockstep: assert property (
        @(posedge clk) disable iff (rst) rec_valid[WB] == wb_fire
    ) else $error("pipe_trace: writeback record out of step with core");

endmodule

// ==== hw/pipeline_core.sv ====
`timescale 1ns/10ps

module pipeline_core #(
    parameter int IMEM_DEPTH = 64,
    parameter int DMEM_DEPTH = 64
) (
    input  logic                          clk,
    input  logic                          rst,
    output logic [$clog2(IMEM_DEPTH)-1:0] fetch_pc,
    input  logic [pipe_pkg::XLEN-1:0]     fetch_instr,
    output logic [pipe_pkg::REG_W-1:0]    rs1_addr,
    output logic [pipe_pkg::REG_W-1:0]    rs2_addr,
    input  logic [pipe_pkg::XLEN-1:0]     rs1_data,
    input  logic [pipe_pkg::XLEN-1:0]     rs2_data,
    output logic                          wb_we,
    output logic [pipe_pkg::REG_W-1:0]    wb_rd,
    output logic [pipe_pkg::XLEN-1:0]     wb_data,
    output logic [pipe_pkg::REG_W-1:0]    ex_rd,
    output logic                          ex_writes,
    output logic [pipe_pkg::REG_W-1:0]    mem_rd,
    output logic                          mem_writes,
    output pipe_pkg::instr_u              dec_instr,
    output logic                          dec_valid,
    input  logic                          stall,
    output logic                          fetch_fire,
    output logic                          wb_fire,
    output logic                          halted
);
    import pipe_pkg::*;

    localparam int DADDR_W = $clog2(DMEM_DEPTH);

    logic [OPC_W-1:0] dec_op;
    logic             dec_is_r;
    logic             dec_wr;
    logic [XLEN-1:0]  dec_imm;
    logic             fetch_stop;

    logic             ex_valid;
    logic [OPC_W-1:0] ex_op;
    logic             ex_wr;
    logic [XLEN-1:0]  ex_a;
    logic [XLEN-1:0]  ex_b;
    logic [XLEN-1:0]  ex_sd;
    logic [XLEN-1:0]  alu_res;

    logic             mem_valid;
    logic [OPC_W-1:0] mem_op;
    logic             mem_wr;
    logic [XLEN-1:0]  mem_res;
    logic [XLEN-1:0]  mem_sd;
    logic [XLEN-1:0]  dmem [DMEM_DEPTH];
    logic [XLEN-1:0]  dmem_rdata;

    logic             wb_valid;
    logic [OPC_W-1:0] wb_op;
    logic             wb_wr;
    logic             halt_done;

    // Decode
    always_comb begin
        dec_op   = dec_instr.r.opcode;
        dec_is_r = dec_op inside {OP_ADD, OP_SUB, OP_AND, OP_OR};
        dec_wr   = dec_is_r || dec_op == OP_ADDI || dec_op == OP_LD;
        dec_imm  = {{(XLEN-IMM_W){dec_instr.i.imm[IMM_W-1]}}, dec_instr.i.imm};
    end

    assign rs1_addr = dec_instr.r.rs1;
    assign rs2_addr = (dec_op == OP_ST) ? dec_instr.i.rd : dec_instr.r.rs2;

    // HALT in decode already blocks the fetch behind it
    assign fetch_fire = !fetch_stop && !(dec_valid && dec_op == OP_HALT) && !stall;

    always_comb begin
        case (ex_op)
            OP_SUB:  alu_res = ex_a - ex_b;
            OP_AND:  alu_res = ex_a & ex_b;
            OP_OR:   alu_res = ex_a | ex_b;
            default: alu_res = ex_a + ex_b;  // ADD, ADDI and LD/ST address
        endcase
    end

    assign dmem_rdata = dmem[mem_res[DADDR_W-1:0]];

    always_ff @(posedge clk) begin
        if (mem_valid && mem_op == OP_ST) begin
            dmem[mem_res[DADDR_W-1:0]] <= mem_sd;
        end
    end

    // Valid bits and fetch control
    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_pc   <= '0;
            fetch_stop <= 1'b0;
            dec_valid  <= 1'b0;
            ex_valid   <= 1'b0;
            mem_valid  <= 1'b0;
            wb_valid   <= 1'b0;
            halt_done  <= 1'b0;
            halted     <= 1'b0;
        end else begin
            if (fetch_fire) begin
                fetch_pc <= fetch_pc + 1'b1;
            end
            if (dec_valid && dec_op == OP_HALT) begin
                fetch_stop <= 1'b1;
            end
            if (!stall) begin
                dec_valid <= fetch_fire;
            end
            // Bubble into execute while decode waits
            ex_valid  <= dec_valid && !stall;
            mem_valid <= ex_valid;
            wb_valid  <= mem_valid;
            if (wb_valid && wb_op == OP_HALT) begin
                halt_done <= 1'b1;
            end
            halted <= halt_done;
        end
    end

    // Stage payload
    always_ff @(posedge clk) begin
        if (!stall) begin
            dec_instr <= fetch_instr;
        end
        ex_op   <= dec_op;
        ex_rd   <= dec_instr.r.rd;
        ex_wr   <= dec_wr;
        ex_a    <= rs1_data;
        ex_b    <= dec_is_r ? rs2_data : dec_imm;
        ex_sd   <= rs2_data;
        mem_op  <= ex_op;
        mem_rd  <= ex_rd;
        mem_wr  <= ex_wr;
        mem_res <= alu_res;
        mem_sd  <= ex_sd;
        wb_op   <= mem_op;
        wb_rd   <= mem_rd;
        wb_wr   <= mem_wr;
        wb_data <= (mem_op == OP_LD) ? dmem_rdata : mem_res;
    end

    assign ex_writes  = ex_valid && ex_wr;
    assign mem_writes = mem_valid && mem_wr;
    assign wb_we      = wb_valid && wb_wr;
    assign wb_fire    = wb_valid;

    // Nothing may drain out of the pipe once the core reports halted
    a_quiet_after_halt: assert property (
        @(posedge clk) disable iff (rst) halted |-> !wb_fire
    ) else $error("pipeline_core: writeback after halt");

endmodule

// ==== hw/hazard_unit.sv ====
`timescale 1ns/10ps

module hazard_unit (
    input  logic                       clk,
    input  logic                       rst,
    input  pipe_pkg::instr_u           dec_instr,
    input  logic                       dec_valid,
    input  logic [pipe_pkg::REG_W-1:0] ex_rd,
    input  logic                       ex_writes,
    input  logic [pipe_pkg::REG_W-1:0] mem_rd,
    input  logic                       mem_writes,
    output logic                       stall
);
    import pipe_pkg::*;

    logic             use_src1;
    logic             use_src2;
    logic [REG_W-1:0] src1;
    logic [REG_W-1:0] src2;
    logic             hit1;
    logic             hit2;

    // Pick the source fields through the view that matches the opcode
    always_comb begin
        use_src1 = 1'b0;
        use_src2 = 1'b0;
        src1     = dec_instr.r.rs1;
        src2     = dec_instr.r.rs2;
        if (dec_valid) begin
            case (dec_instr.r.opcode)
                OP_ADD, OP_SUB, OP_AND, OP_OR: begin
                    use_src1 = 1'b1;
                    use_src2 = 1'b1;
                end
                OP_ADDI, OP_LD: begin
                    use_src1 = 1'b1;
                end
                OP_ST: begin
                    // Store data comes from the rd field
                    use_src1 = 1'b1;
                    use_src2 = 1'b1;
                    src2     = dec_instr.i.rd;
                end
                default: begin
                    use_src1 = 1'b0;
                end
            endcase
        end
    end

    // r0 never waits on anyone
    assign hit1 = use_src1 && src1 != '0 &&
                  ((ex_writes && ex_rd == src1) || (mem_writes && mem_rd == src1));
    assign hit2 = use_src2 && src2 != '0 &&
                  ((ex_writes && ex_rd == src2) || (mem_writes && mem_rd == src2));

    assign stall = hit1 || hit2;

    // A producer clears memory two cycles after decode starts waiting on it
    a_stall_bounded: assert property (
        @(posedge clk) disable iff (rst) (stall && $past(stall)) |=> !stall
    ) else $error("hazard_unit: decode stalled for more than two cycles");

endmodule

// ==== hw/reg_file.sv ====
`timescale 1ns/10ps

module reg_file (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [pipe_pkg::REG_W-1:0] rs1_addr,
    input  logic [pipe_pkg::REG_W-1:0] rs2_addr,
    output logic [pipe_pkg::XLEN-1:0]  rs1_data,
    output logic [pipe_pkg::XLEN-1:0]  rs2_data,
    input  logic                       wb_we,
    input  logic [pipe_pkg::REG_W-1:0] wb_rd,
    input  logic [pipe_pkg::XLEN-1:0]  wb_data
);
    import pipe_pkg::*;

    localparam int NREG = 1 << REG_W;

    logic [XLEN-1:0] regs [NREG];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NREG; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // Writes bypass to the read ports so decode sees writeback data the same cycle
    always_comb begin
        rs1_data = regs[rs1_addr];
        if (wb_we && wb_rd == rs1_addr) begin
            rs1_data = wb_data;
        end
        if (rs1_addr == '0) begin
            rs1_data = '0;
        end
    end

    always_comb begin
        rs2_data = regs[rs2_addr];
        if (wb_we && wb_rd == rs2_addr) begin
            rs2_data = wb_data;
        end
        if (rs2_addr == '0) begin
            rs2_data = '0;
        end
    end

    // Stored r0 keeps its zero when writeback targets it
    a_r0_sticks: assert property (
        @(posedge clk) disable iff (rst)
        (wb_we && wb_rd == '0) |=> regs[0] == '0
    ) else $error("reg_file: r0 storage changed by a write");

endmodule

// ==== hw/instr_mem.sv ====
`timescale 1ns/10ps

module instr_mem #(
    parameter int IMEM_DEPTH = 64
) (
    input  logic                          clk,
    input  logic                          prog_we,
    input  logic [$clog2(IMEM_DEPTH)-1:0] prog_addr,
    input  logic [pipe_pkg::XLEN-1:0]     prog_data,
    input  logic [$clog2(IMEM_DEPTH)-1:0] fetch_pc,
    output logic [pipe_pkg::XLEN-1:0]     fetch_instr
);
    import pipe_pkg::*;

    logic [XLEN-1:0] mem [IMEM_DEPTH];

    // Program load port, one word per strobe
    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_data;
        end
    end

    // Fetch sees the word in the same cycle
    assign fetch_instr = mem[fetch_pc];

    // Load address must fall inside the array for non power of two depths
    a_prog_addr_range: assert property (
        @(posedge clk) prog_we |-> (32'(prog_addr) < IMEM_DEPTH)
    ) else $error("instr_mem: prog_addr %0d out of range", prog_addr);

endmodule

// ==== common/pipe_pkg.sv ====
package pipe_pkg;

    // Datapath and instruction word width
    localparam int XLEN = 16;

    // Register index width, eight registers
    localparam int REG_W = 3;

    localparam int OPC_W = 4;
    localparam int IMM_W = 6;

    // Width of the per-instruction decode stall counter
    localparam int STALL_W = 4;

    localparam logic [OPC_W-1:0] OP_NOP  = 4'd0;
    localparam logic [OPC_W-1:0] OP_ADD  = 4'd1;
    localparam logic [OPC_W-1:0] OP_SUB  = 4'd2;
    localparam logic [OPC_W-1:0] OP_AND  = 4'd3;
    localparam logic [OPC_W-1:0] OP_OR   = 4'd4;
    localparam logic [OPC_W-1:0] OP_ADDI = 4'd5;
    localparam logic [OPC_W-1:0] OP_LD   = 4'd6;
    // ST stores the register named by rd
    localparam logic [OPC_W-1:0] OP_ST   = 4'd7;
    localparam logic [OPC_W-1:0] OP_HALT = 4'd15;

    // Register format
    typedef struct packed {
        logic [OPC_W-1:0] opcode;
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] rs1;
        logic [REG_W-1:0] rs2;
        logic [2:0]       pad;
    } instr_r_t;

    // Immediate format, imm is signed
    typedef struct packed {
        logic [OPC_W-1:0] opcode;
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] rs1;
        logic [IMM_W-1:0] imm;
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

endpackage
